// File: compile.f
+incdir+src
src/dcache_pkg.sv
src/line_mem.sv
src/dcache_core.sv
src/dcache_stats.sv
src/dcache_top.sv
sim/dcache_chk.sv
sim/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dcache_tb
FILELIST  := compile.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation completed successfully
SOURCES   := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "RUN PASSED" || (echo "RUN FAILED"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;

    localparam int TIMEOUT   = 200; // Cycles allowed per wait
    localparam int WIN_LINES = 32;  // Keeps indices colliding
    localparam int MEM_BYTES = 1 << `DC_ADDR_WIDTH;

    logic                    clk;
    logic                    rstn;
    logic                    cpu_req;
    dcache_pkg::dc_cpu_req_t cpu_in;
    logic                    cpu_ready;
    dcache_pkg::dc_word_t    cpu_rdata;
    logic                    cpu_rvalid;
    logic                    stat_clr;
    logic [1:0]              stat_sel;
    dcache_pkg::dc_count_t   stat_data;

    logic [7:0] ref_mem [MEM_BYTES]; // Byte model of the whole space
    logic       tag_valid [`DC_N_LINES];
    int         tag_val [`DC_N_LINES];
    logic       tag_dirty [`DC_N_LINES];
    int         n_hit;
    int         n_miss;
    int         n_wb;
    int         pass_count;
    int         err_count;
    int         seed;

    dcache_top dcache_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_in     (cpu_in),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .stat_clr   (stat_clr),
        .stat_sel   (stat_sel),
        .stat_data  (stat_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!cpu_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ready) abort_run("cpu_ready was expected to return high but stayed low");
    endtask

    task automatic wait_rvalid();
        int n;
        n = 0;
        while (!cpu_rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_rvalid) abort_run("a load was accepted but cpu_rvalid never pulsed");
    endtask

    // Little endian, zero extended
    function automatic logic [31:0] load_expect(input dcache_pkg::dc_addr_t addr,
                                                input dcache_pkg::dc_size_t size);
        logic [31:0] val;
        int nbytes;
        val = '0;
        nbytes = 1 << size;
        for (int i = 0; i < nbytes; i++) begin
            val[i*8 +: 8] = ref_mem[int'(addr) + i];
        end
        return val;
    endfunction

    task automatic apply_store(input dcache_pkg::dc_addr_t addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, input dcache_pkg::dc_size_t size);
        int base;
        int lo;
        int nbytes;
        base = int'(addr) & ~3;
        lo = int'(addr) & 3;
        nbytes = 1 << size;
        for (int l = 0; l < 4; l++) begin
            if (wstrb != 4'b0000 ? wstrb[l] : (l >= lo && l < lo + nbytes)) begin
                ref_mem[base + l] = wdata[l*8 +: 8]; // Data sits in its byte lane
            end
        end
    endtask

    task automatic update_tags(input logic wr, input dcache_pkg::dc_addr_t addr);
        int line_no;
        int idx;
        int tag;
        line_no = int'(addr) / `DC_LINE_BYTES;
        idx = line_no % `DC_N_LINES;
        tag = line_no / `DC_N_LINES;
        if (tag_valid[idx] && tag_val[idx] == tag) begin
            n_hit++;
            if (wr) tag_dirty[idx] = 1'b1;
        end else begin
            n_miss++;
            if (tag_valid[idx] && tag_dirty[idx]) n_wb++; // Dirty victim
            tag_valid[idx] = 1'b1;
            tag_val[idx] = tag;
            tag_dirty[idx] = wr;
        end
    endtask

    task automatic cache_access(input logic wr, input dcache_pkg::dc_addr_t addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb,
                                input dcache_pkg::dc_size_t size);
        logic [31:0] exp;
        wait_ready();
        cpu_req = 1'b1;
        cpu_in.wr = wr;
        cpu_in.addr = addr;
        cpu_in.wdata = wdata;
        cpu_in.wstrb = wstrb;
        cpu_in.size = size;
        exp = load_expect(addr, size);
        update_tags(wr, addr);
        if (wr) apply_store(addr, wdata, wstrb, size);
        @(negedge clk); // Accepted at the rising edge in between
        cpu_req = 1'b0;
        if (wr) begin
            wait_ready();
            check_val("cpu_rvalid after a store", {31'b0, cpu_rvalid}, 32'd0);
        end else begin
            wait_rvalid();
            check_val($sformatf("load at %h size %0d", addr, size), cpu_rdata, exp);
        end
    endtask

    task automatic read_stat(input logic [1:0] sel, output dcache_pkg::dc_count_t val);
        stat_sel = sel;
        @(negedge clk);
        val = stat_data;
    endtask

    function automatic dcache_pkg::dc_addr_t rand_addr(input dcache_pkg::dc_size_t size);
        int a;
        a = $random(seed) & (WIN_LINES * `DC_LINE_BYTES - 1);
        a = a & ~((1 << size) - 1); // Natural alignment
        return dcache_pkg::dc_addr_t'(a);
    endfunction

    task automatic report_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_at_start);
        end
    endtask

    initial begin
        int                    e0;
        int                    wb_before;
        dcache_pkg::dc_count_t cnt;
        dcache_pkg::dc_count_t wb0;
        dcache_pkg::dc_addr_t  a;
        dcache_pkg::dc_size_t  sz;
        logic                  wr;
        logic [3:0]            strb;
        logic [31:0]           wd;

        seed = 32'h8d67;
        rstn = 1'b0;
        cpu_req = 1'b0;
        cpu_in = '0;
        stat_clr = 1'b0;
        stat_sel = 2'd0;
        n_hit = 0;
        n_miss = 0;
        n_wb = 0;
        pass_count = 0;
        err_count = 0;
        for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;
        for (int i = 0; i < `DC_N_LINES; i++) begin
            tag_valid[i] = 1'b0;
            tag_val[i] = 0;
            tag_dirty[i] = 1'b0;
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        e0 = err_count;
        check_val("cpu_ready after reset", {31'b0, cpu_ready}, 32'd1);
        for (int s = 0; s < 3; s++) begin
            read_stat(2'(s), cnt);
            check_val($sformatf("counter %0d after reset", s), 32'(cnt), 32'd0);
        end
        report_test("Test 1 reset state", e0);

        e0 = err_count;
        for (int i = 0; i < 300; i++) begin
            wr = 1'($random(seed));
            a = rand_addr(dcache_pkg::SIZE_WORD);
            wd = $random(seed);
            cache_access(wr, a, wd, 4'b0000, dcache_pkg::SIZE_WORD);
        end
        report_test("Test 2 random word access", e0);

        e0 = err_count;
        for (int i = 0; i < 200; i++) begin
            wr = 1'($random(seed));
            sz = dcache_pkg::dc_size_t'($unsigned($random(seed)) % 3);
            a = rand_addr(sz);
            wd = $random(seed);
            strb = 1'($random(seed)) ? 4'($random(seed)) : 4'b0000;
            cache_access(wr, a, wd, strb, sz);
        end
        report_test("Test 3 sub-word access", e0);

        // Three tags on index 2
        e0 = err_count;
        read_stat(2'd2, wb0);
        wb_before = n_wb;
        cache_access(1'b1, 12'h0A4, $random(seed), 4'b0000, dcache_pkg::SIZE_WORD);
        cache_access(1'b0, 12'h0E4, 32'h0, 4'b0000, dcache_pkg::SIZE_WORD);
        cache_access(1'b0, 12'h124, 32'h0, 4'b0000, dcache_pkg::SIZE_WORD);
        cache_access(1'b0, 12'h0A4, 32'h0, 4'b0000, dcache_pkg::SIZE_WORD);
        read_stat(2'd2, cnt);
        check_val("writeback counter advance", 32'(dcache_pkg::dc_count_t'(cnt - wb0)),
                  32'(n_wb - wb_before));
        report_test("Test 4 dirty conflict", e0);

        e0 = err_count;
        read_stat(2'd0, cnt);
        check_val("hit counter", 32'(cnt), 32'(dcache_pkg::dc_count_t'(n_hit)));
        read_stat(2'd1, cnt);
        check_val("miss counter", 32'(cnt), 32'(dcache_pkg::dc_count_t'(n_miss)));
        read_stat(2'd2, cnt);
        check_val("writeback counter", 32'(cnt), 32'(dcache_pkg::dc_count_t'(n_wb)));
        read_stat(2'd3, cnt);
        check_val("unused counter select", 32'(cnt), 32'd0);
        stat_clr = 1'b1;
        @(negedge clk);
        stat_clr = 1'b0;
        for (int s = 0; s < 3; s++) begin
            read_stat(2'(s), cnt);
            check_val($sformatf("counter %0d after clear", s), 32'(cnt), 32'd0);
        end
        report_test("Test 5 statistics", e0);

        $display("Checks passed: %0d, errors: %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
    input logic                    clk,
    input logic                    rstn,
    input logic                    cpu_req,
    input dcache_pkg::dc_cpu_req_t cpu_in,
    input logic                    cpu_ready,
    input logic                    cpu_rvalid,
    input logic                    mem_req,
    input dcache_pkg::dc_mem_req_t mem_out,
    input logic                    mem_gnt,
    input dcache_pkg::dc_state_e   state
);

    logic load_taken;

    assign load_taken = cpu_req && cpu_ready && !cpu_in.wr;

    // Back to back hits give adjacent pulses
    rvalid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cpu_rvalid && !load_taken |=> !cpu_rvalid)
        else $error("cpu_rvalid high for more than one cycle per load");

    mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_out))
        else $error("memory request dropped or changed before grant");

    ready_idle: assert property (@(posedge clk) disable iff (!rstn)
        state != dcache_pkg::S_IDLE |-> !cpu_ready)
        else $error("cpu_ready high while a miss is in progress");

endmodule

bind dcache_core dcache_chk dcache_chk_i (
    .clk        (clk),
    .rstn       (rstn),
    .cpu_req    (cpu_req),
    .cpu_in     (cpu_in),
    .cpu_ready  (cpu_ready),
    .cpu_rvalid (cpu_rvalid),
    .mem_req    (mem_req),
    .mem_out    (mem_out),
    .mem_gnt    (mem_gnt),
    .state      (state)
);

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    cpu_req,
    input  dcache_pkg::dc_cpu_req_t cpu_in,
    output logic                    cpu_ready,
    output dcache_pkg::dc_word_t    cpu_rdata,
    output logic                    cpu_rvalid,
    input  logic                    stat_clr,
    input  logic [1:0]              stat_sel,
    output dcache_pkg::dc_count_t   stat_data
);

    logic                    mem_req;
    dcache_pkg::dc_mem_req_t mem_cmd;
    logic                    mem_gnt;
    logic                    mem_rvalid;
    dcache_pkg::dc_line_t    mem_rdata;
    dcache_pkg::dc_event_t   evt;

    dcache_core dcache_core_i (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_in     (cpu_in),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .mem_req    (mem_req),
        .mem_out    (mem_cmd),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .evt        (evt)
    );

    line_mem line_mem_i (
        .clk        (clk),
        .rstn       (rstn),
        .mem_req    (mem_req),
        .mem_in     (mem_cmd),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    dcache_stats dcache_stats_i (
        .clk       (clk),
        .rstn      (rstn),
        .evt       (evt),
        .stat_clr  (stat_clr),
        .stat_sel  (stat_sel),
        .stat_data (stat_data)
    );

endmodule

// File: src/dcache_stats.sv
`timescale 1ns/1ps

module dcache_stats (
    input  logic                  clk,
    input  logic                  rstn,
    input  dcache_pkg::dc_event_t evt,
    input  logic                  stat_clr,
    input  logic [1:0]            stat_sel,
    output dcache_pkg::dc_count_t stat_data
);

    dcache_pkg::dc_count_t cnt [3]; // Hits, misses, writebacks
    logic [2:0] inc;

    assign inc = {evt.writeback, evt.miss, evt.hit};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else if (stat_clr) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (inc[i]) begin
                    cnt[i] <= cnt[i] + 1'b1; // Wraps
                end
            end
        end
    end

    always_comb begin
        case (stat_sel)
            2'd0:    stat_data = cnt[0];
            2'd1:    stat_data = cnt[1];
            2'd2:    stat_data = cnt[2];
            default: stat_data = '0;
        endcase
    end

endmodule

// File: src/dcache_core.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_core (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   cpu_req,
    input  dcache_pkg::dc_cpu_req_t cpu_in,
    output logic                   cpu_ready,
    output dcache_pkg::dc_word_t   cpu_rdata,
    output logic                   cpu_rvalid,
    output logic                   mem_req,
    output dcache_pkg::dc_mem_req_t mem_out,
    input  logic                   mem_gnt,
    input  logic                   mem_rvalid,
    input  dcache_pkg::dc_line_t   mem_rdata,
    output dcache_pkg::dc_event_t  evt
);

    localparam int OFFSET_BITS   = $clog2(`DC_LINE_BYTES);
    localparam int IDX_BITS      = $clog2(`DC_N_LINES);
    localparam int TAG_BITS      = `DC_ADDR_WIDTH - OFFSET_BITS - IDX_BITS;
    localparam int WORD_OFF_BITS = $clog2(`DC_LINE_BYTES / 4);

    logic [TAG_BITS-1:0]  tag_arr  [`DC_N_LINES];
    dcache_pkg::dc_line_t data_arr [`DC_N_LINES];
    logic [`DC_N_LINES-1:0] valid_arr;
    logic [`DC_N_LINES-1:0] dirty_arr;

    dcache_pkg::dc_state_e   state;
    dcache_pkg::dc_cpu_req_t pend;    // Request waiting on a miss
    dcache_pkg::dc_cpu_req_t cur_req; // Incoming request, strobes resolved

    logic [IDX_BITS-1:0]      cur_idx;
    logic [TAG_BITS-1:0]      cur_tag;
    logic [WORD_OFF_BITS-1:0] cur_word;
    logic [1:0]               cur_byte;
    logic [IDX_BITS-1:0]      pend_idx;
    logic [TAG_BITS-1:0]      pend_tag;
    logic [WORD_OFF_BITS-1:0] pend_word;
    logic [1:0]               pend_byte;

    logic req_fire;
    logic cur_hit;
    logic victim_dirty;
    logic wb_grant;
    logic refill_done;

    function automatic dcache_pkg::dc_strb_t gen_strb(
        input logic [1:0]           byte_off,
        input dcache_pkg::dc_size_t size
    );
        dcache_pkg::dc_strb_t strb;
        case (size)
            dcache_pkg::SIZE_BYTE: strb = 4'b0001 << byte_off;
            dcache_pkg::SIZE_HALF: strb = byte_off[1] ? 4'b1100 : 4'b0011;
            default:               strb = 4'b1111;
        endcase
        return strb;
    endfunction

    // Zero extended, naturally aligned
    function automatic dcache_pkg::dc_word_t load_extract(
        input dcache_pkg::dc_line_t   line,
        input logic [WORD_OFF_BITS-1:0] word_idx,
        input logic [1:0]             byte_off,
        input dcache_pkg::dc_size_t   size
    );
        dcache_pkg::dc_word_t word;
        dcache_pkg::dc_word_t result;
        word = line[word_idx*32 +: 32];
        case (size)
            dcache_pkg::SIZE_BYTE: result = {24'h0, word[byte_off*8 +: 8]};
            dcache_pkg::SIZE_HALF: result = {16'h0, word[byte_off[1]*16 +: 16]};
            default:               result = word;
        endcase
        return result;
    endfunction

    function automatic dcache_pkg::dc_line_t store_merge(
        input dcache_pkg::dc_line_t   line,
        input logic [WORD_OFF_BITS-1:0] word_idx,
        input dcache_pkg::dc_word_t   wdata,
        input dcache_pkg::dc_strb_t   wstrb
    );
        dcache_pkg::dc_line_t merged;
        merged = line;
        for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) begin
                merged[word_idx*32 + i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign cur_idx   = cpu_in.addr[OFFSET_BITS +: IDX_BITS];
    assign cur_tag   = cpu_in.addr[`DC_ADDR_WIDTH-1 -: TAG_BITS];
    assign cur_word  = cpu_in.addr[OFFSET_BITS-1:2];
    assign cur_byte  = cpu_in.addr[1:0];
    assign pend_idx  = pend.addr[OFFSET_BITS +: IDX_BITS];
    assign pend_tag  = pend.addr[`DC_ADDR_WIDTH-1 -: TAG_BITS];
    assign pend_word = pend.addr[OFFSET_BITS-1:2];
    assign pend_byte = pend.addr[1:0];

    always_comb begin
        cur_req = cpu_in;
        if (cpu_in.wstrb == 4'b0000) begin
            cur_req.wstrb = gen_strb(cur_byte, cpu_in.size);
        end
    end

    assign req_fire     = cpu_req && cpu_ready && (state == dcache_pkg::S_IDLE);
    assign cur_hit      = valid_arr[cur_idx] && (tag_arr[cur_idx] == cur_tag);
    assign victim_dirty = valid_arr[cur_idx] && dirty_arr[cur_idx];
    assign wb_grant     = (state == dcache_pkg::S_WRITEBACK) && mem_gnt;
    assign refill_done  = (state == dcache_pkg::S_REFILL) && mem_rvalid;

    assign evt.hit       = req_fire && cur_hit;
    assign evt.miss      = req_fire && !cur_hit;
    assign evt.writeback = wb_grant;

    // Control and line status
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= dcache_pkg::S_IDLE;
            cpu_ready  <= 1'b1;
            cpu_rvalid <= 1'b0;
            mem_req    <= 1'b0;
            valid_arr  <= '0;
            dirty_arr  <= '0;
        end else begin
            cpu_rvalid <= 1'b0;
            case (state)
                dcache_pkg::S_IDLE: begin
                    if (req_fire && cur_hit) begin
                        if (cpu_in.wr) begin
                            dirty_arr[cur_idx] <= 1'b1;
                        end else begin
                            cpu_rvalid <= 1'b1;
                        end
                    end else if (req_fire) begin
                        cpu_ready <= 1'b0;
                        mem_req   <= 1'b1;
                        state     <= victim_dirty ? dcache_pkg::S_WRITEBACK
                                                  : dcache_pkg::S_REFILL;
                    end
                end
                dcache_pkg::S_WRITEBACK: begin
                    if (mem_gnt) begin
                        state <= dcache_pkg::S_REFILL; // Request stays up as a read
                    end
                end
                dcache_pkg::S_REFILL: begin
                    if (mem_gnt) begin
                        mem_req <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        valid_arr[pend_idx] <= 1'b1;
                        dirty_arr[pend_idx] <= pend.wr; // Merged store dirties the line
                        cpu_rvalid          <= !pend.wr;
                        cpu_ready           <= 1'b1;
                        state               <= dcache_pkg::S_IDLE;
                    end
                end
                default: state <= dcache_pkg::S_IDLE;
            endcase
        end
    end

    // Arrays and payload
    always_ff @(posedge clk) begin
        if (req_fire && cur_hit) begin
            if (cpu_in.wr) begin
                data_arr[cur_idx] <= store_merge(data_arr[cur_idx], cur_word,
                                                 cpu_in.wdata, cur_req.wstrb);
            end else begin
                cpu_rdata <= load_extract(data_arr[cur_idx], cur_word, cur_byte, cpu_in.size);
            end
        end else if (req_fire) begin
            pend          <= cur_req;
            mem_out.we    <= victim_dirty;
            mem_out.wdata <= data_arr[cur_idx];
            if (victim_dirty) begin
                mem_out.addr <= {tag_arr[cur_idx], cur_idx, {OFFSET_BITS{1'b0}}};
            end else begin
                mem_out.addr <= {cpu_in.addr[`DC_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
        end

        if (wb_grant) begin
            mem_out.we   <= 1'b0;
            mem_out.addr <= {pend.addr[`DC_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end

        if (refill_done) begin
            tag_arr[pend_idx] <= pend_tag;
            if (pend.wr) begin
                data_arr[pend_idx] <= store_merge(mem_rdata, pend_word, pend.wdata, pend.wstrb);
            end else begin
                data_arr[pend_idx] <= mem_rdata;
                cpu_rdata          <= load_extract(mem_rdata, pend_word, pend_byte, pend.size);
            end
        end
    end

endmodule

// File: src/line_mem.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module line_mem (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    mem_req,
    input  dcache_pkg::dc_mem_req_t mem_in,
    output logic                    mem_gnt,
    output logic                    mem_rvalid,
    output dcache_pkg::dc_line_t    mem_rdata
);

    localparam int OFFSET_BITS = $clog2(`DC_LINE_BYTES);
    localparam int IDX_BITS    = $clog2(`DC_MEM_LINES);
    localparam int LAT_W       = $clog2(`DC_MEM_LATENCY + 1);

    dcache_pkg::dc_line_t mem_arr [`DC_MEM_LINES];

    logic [LAT_W-1:0]    busy_cnt;
    logic                rd_pend;  // Access in flight is a read
    logic [IDX_BITS-1:0] line_idx;

    assign line_idx = mem_in.addr[OFFSET_BITS +: IDX_BITS];

    // One access at a time
    assign mem_gnt    = mem_req && (busy_cnt == '0);
    assign mem_rvalid = rd_pend && (busy_cnt == LAT_W'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_cnt <= '0;
            rd_pend  <= 1'b0;
            for (int i = 0; i < `DC_MEM_LINES; i++) begin
                mem_arr[i] <= '0;
            end
        end else begin
            if (mem_gnt) begin
                busy_cnt <= LAT_W'(`DC_MEM_LATENCY);
                rd_pend  <= !mem_in.we;
                if (mem_in.we) begin
                    mem_arr[line_idx] <= mem_in.wdata; // Write lands at grant
                end
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
                if (busy_cnt == LAT_W'(1)) begin
                    rd_pend <= 1'b0;
                end
            end
        end
    end

    // Read line sampled at grant, shown when the count runs out
    always_ff @(posedge clk) begin
        if (mem_gnt && !mem_in.we) begin
            mem_rdata <= mem_arr[line_idx];
        end
    end

endmodule

// File: src/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_WIDTH-1:0]   dc_addr_t;
    typedef logic [31:0]                 dc_word_t;
    typedef logic [`DC_LINE_BYTES*8-1:0] dc_line_t;
    typedef logic [3:0]                  dc_strb_t;
    typedef logic [1:0]                  dc_size_t;
    typedef logic [`DC_CNT_WIDTH-1:0]    dc_count_t;

    localparam dc_size_t SIZE_BYTE = 2'b00;
    localparam dc_size_t SIZE_HALF = 2'b01;
    localparam dc_size_t SIZE_WORD = 2'b10;

    typedef enum logic [1:0] {
        S_IDLE      = 2'b00,
        S_WRITEBACK = 2'b01, // Dirty victim out
        S_REFILL    = 2'b10  // Wait for the new line
    } dc_state_e;

    typedef struct packed {
        logic     wr;        // 1 store, 0 load
        dc_addr_t addr;
        dc_word_t wdata;
        dc_strb_t wstrb;     // Zero means derive from size
        dc_size_t size;
    } dc_cpu_req_t;

    typedef struct packed {
        logic     we;
        dc_addr_t addr;      // Line aligned
        dc_line_t wdata;
    } dc_mem_req_t;

    typedef struct packed {
        logic hit;
        logic miss;
        logic writeback;
    } dc_event_t;

endpackage

// File: src/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Byte address width
`define DC_ADDR_WIDTH 12

`define DC_LINE_BYTES 16 // Bytes per cache line
`define DC_N_LINES 4     // Direct mapped, one way

// Backing memory covers the whole address space
`define DC_MEM_LINES ((1 << `DC_ADDR_WIDTH) / `DC_LINE_BYTES)

// Grant to completion, in cycles
`define DC_MEM_LATENCY 3

`define DC_CNT_WIDTH 16 // Statistics counters

`endif
